/* hw/dmac_config.svh */
// Macros for FIFO depth, bus address width, longword count width and burst limit
`ifndef DMAC_CONFIG_SVH
`define DMAC_CONFIG_SVH

// Longwords held in the FIFO
`define DMAC_FIFO_DEPTH 8

// CPU bus address width
`define DMAC_ADDR_W 32

// Width of the longword counter
`define DMAC_COUNT_W 16

// Longwords per bus tenure before mastership is released
`define DMAC_BURST_MAX 4

`endif

/* hw/dmacPkg.sv */
// Package dmacPkg with transfer direction, FSM state, termination enums and status structs
`default_nettype none
`include "dmac_config.svh"

package dmacPkg;

    typedef enum logic {
        memRead  = 1'b0,               // Memory to peripheral
        memWrite = 1'b1                // Peripheral to memory
    } xferDirT;

    typedef enum logic [2:0] {
        idle,
        request,
        granted,
        address,
        strobe,
        waitTerm,
        recover
    } cpuSmStateT;

    typedef enum logic [1:0] {
        termNone,
        term32,
        term16
    } termKindT;

    typedef struct packed {
        logic                               empty;
        logic                               full;
        logic [$clog2(`DMAC_FIFO_DEPTH):0]  level;   // Longwords held
    } fifoStatusT;

    // Per-clock bus cycle controls from the FSM to the pin block
    typedef struct packed {
        logic master;                  // Bus owned, nBgack low
        logic strobe;                  // nAs and nDs asserted
        logic rw;                      // High for a memory read
        logic upperHalf;               // Full longword or its upper word
        logic addrStep;                // Advance the address counter
        logic capture;                 // Push the assembled read longword
    } busCycleT;

endpackage

`default_nettype wire

/* hw/peripheralPort.sv */
// Module peripheralPort: halfword packing into longwords and longword splitting into halfwords
`timescale 1ns/10ps
`default_nettype none

module peripheralPort (
    input  wire                        CLK,
    input  wire                        nRESET,
    input  wire                        periphWrStb,
    input  wire [15:0]                 periphWrData,
    input  wire                        periphRdStb,
    output logic [15:0]                periphRdData,
    output logic                       periphFull,
    output logic                       periphEmpty,
    output logic [31:0]                fifoWrData,
    output logic                       fifoPush,
    input  wire [31:0]                 fifoRdData,
    output logic                       fifoPop,
    input  wire dmacPkg::fifoStatusT   fifoStatus
);

    logic        wrHalf;               // Upper half already held
    logic [15:0] wrUpper;
    logic        pairValid;            // Longword waiting for FIFO room
    logic        rdHalf;               // Lower half on periphRdData
    logic        wrTake;
    logic        rdTake;

    always_comb begin
        periphFull   = fifoStatus.full && !wrHalf;
        periphEmpty  = fifoStatus.empty;
        wrTake       = periphWrStb && !periphFull;
        rdTake       = periphRdStb && !periphEmpty;
        fifoPush     = pairValid && !fifoStatus.full;
        fifoPop      = rdTake && rdHalf;           // Second strobe frees the longword
        periphRdData = rdHalf ? fifoRdData[15:0] : fifoRdData[31:16];
    end

    always_ff @(posedge CLK or negedge nRESET) begin
        if (!nRESET) begin
            wrHalf    <= 1'b0;
            pairValid <= 1'b0;
            rdHalf    <= 1'b0;
        end else begin
            if (wrTake) begin
                wrHalf <= !wrHalf;
            end
            if (wrTake && wrHalf) begin
                pairValid <= 1'b1;
            end else if (fifoPush) begin
                pairValid <= 1'b0;
            end
            if (rdTake) begin
                rdHalf <= !rdHalf;
            end
        end
    end

    // Big-endian pairing, first halfword is the upper half
    always_ff @(posedge CLK) begin
        if (wrTake && !wrHalf) begin
            wrUpper <= periphWrData;
        end
        if (wrTake && wrHalf) begin
            fifoWrData <= {wrUpper, periphWrData};
        end
    end

endmodule

`default_nettype wire

/* hw/dmaFifo.sv */
// Module dmaFifo: circular longword buffer with level counter and empty/full status
`timescale 1ns/10ps
`default_nettype none
`include "dmac_config.svh"

module dmaFifo (
    input  wire                        CLK,
    input  wire                        nRESET,
    input  wire                        start,
    input  wire [31:0]                 wrData,
    input  wire                        push,
    output logic [31:0]                rdData,
    input  wire                        pop,
    output dmacPkg::fifoStatusT        status
);

    localparam int Depth  = `DMAC_FIFO_DEPTH;
    localparam int PtrW   = $clog2(Depth);
    localparam int LevelW = PtrW + 1;

    logic [31:0]       mem [Depth];
    logic [PtrW-1:0]   wrPtr;
    logic [PtrW-1:0]   rdPtr;
    logic [LevelW-1:0] level;
    logic              doPush;
    logic              doPop;

    function automatic logic [PtrW-1:0] nextPtr(input logic [PtrW-1:0] ptr);
        return (ptr == PtrW'(Depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_comb begin
        status.level = level;
        status.empty = (level == '0);
        status.full  = (level == LevelW'(Depth));
        doPush       = push && !status.full;       // Overflow dropped
        doPop        = pop && !status.empty;
        rdData       = mem[rdPtr];                 // Head is always visible
    end

    always_ff @(posedge CLK or negedge nRESET) begin
        if (!nRESET) begin
            wrPtr <= '0;
            rdPtr <= '0;
            level <= '0;
        end else if (start) begin
            wrPtr <= '0;
            rdPtr <= '0;
            level <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (doPop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            case ({doPush, doPop})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (doPush) begin
            mem[wrPtr] <= wrData;
        end
    end

endmodule

`default_nettype wire

/* hw/cpuBusSm.sv */
// Module cpuBusSm: bus arbitration and bus cycle FSM with longword and burst counters
`timescale 1ns/10ps
`default_nettype none
`include "dmac_config.svh"

module cpuBusSm (
    input  wire                        CLK,
    input  wire                        nRESET,
    input  wire                        start,
    input  wire                        dmaEna,
    input  wire dmacPkg::xferDirT      dmaDir,
    input  wire [`DMAC_COUNT_W-1:0]    longCount,
    input  wire dmacPkg::fifoStatusT   fifoStatus,
    input  wire dmacPkg::termKindT     term,
    input  wire                        nBg,
    output logic                       nBr,
    output logic                       nBgack,
    output dmacPkg::busCycleT          cycle,
    output logic                       fifoPop,
    output logic                       xferDone
);

    localparam int BurstW = $clog2(`DMAC_BURST_MAX + 1);
    localparam int LevelW = $clog2(`DMAC_FIFO_DEPTH) + 1;

    dmacPkg::cpuSmStateT      state;
    logic [`DMAC_COUNT_W-1:0] count;
    logic [BurstW-1:0]        burst;
    logic                     half;        // Lower word cycle of a 16-bit port
    logic                     isWrite;
    logic                     reqCond;
    logic                     termSeen;
    logic                     finishing;
    logic                     keepBus;

    always_comb begin
        isWrite   = (dmaDir == dmacPkg::memWrite);
        reqCond   = dmaEna && (count != '0) &&
                    (isWrite ? !fifoStatus.empty : !fifoStatus.full);
        termSeen  = (state == dmacPkg::waitTerm) && (term != dmacPkg::termNone);
        finishing = termSeen && !((term == dmacPkg::term16) && !half);
        // Status still predates this pop or push, hence the margin of one
        keepBus   = dmaEna && (count != 1) && ((burst + 1'b1) < `DMAC_BURST_MAX) &&
                    (isWrite ? (fifoStatus.level >= LevelW'(2))
                             : (fifoStatus.level < LevelW'(`DMAC_FIFO_DEPTH - 1)));
    end

    always_ff @(posedge CLK or negedge nRESET) begin
        if (!nRESET) begin
            state  <= dmacPkg::idle;
            nBr    <= 1'b1;
            nBgack <= 1'b1;
            count  <= '0;
            burst  <= '0;
            half   <= 1'b0;
        end else begin
            if (start) begin
                count <= longCount;
            end else if (finishing) begin
                count <= count - 1'b1;
            end
            case (state)
                dmacPkg::idle: begin
                    if (reqCond) begin
                        nBr   <= 1'b0;
                        state <= dmacPkg::request;
                    end
                end
                dmacPkg::request: begin
                    if (!reqCond) begin
                        nBr   <= 1'b1;             // Withdrawn before grant
                        state <= dmacPkg::idle;
                    end else if (!nBg) begin
                        nBr    <= 1'b1;
                        nBgack <= 1'b0;
                        burst  <= '0;
                        half   <= 1'b0;
                        state  <= dmacPkg::granted;
                    end
                end
                dmacPkg::granted, dmacPkg::address: begin
                    state <= dmacPkg::strobe;
                end
                dmacPkg::strobe: begin
                    state <= dmacPkg::waitTerm;
                end
                dmacPkg::waitTerm: begin
                    if (termSeen && !finishing) begin
                        half  <= 1'b1;             // Lower word cycle follows
                        state <= dmacPkg::address;
                    end else if (finishing) begin
                        half  <= 1'b0;
                        burst <= burst + 1'b1;
                        if (keepBus) begin
                            state <= dmacPkg::address;
                        end else begin
                            nBgack <= 1'b1;
                            state  <= dmacPkg::recover;
                        end
                    end
                end
                dmacPkg::recover: begin
                    state <= dmacPkg::idle;        // nBgack high for one clock
                end
                default: begin
                    state <= dmacPkg::idle;
                end
            endcase
        end
    end

    always_comb begin
        cycle.master    = !nBgack;
        cycle.strobe    = (state == dmacPkg::strobe) || (state == dmacPkg::waitTerm);
        cycle.rw        = !(!nBgack && isWrite);
        cycle.upperHalf = !half;
        cycle.addrStep  = termSeen;
        cycle.capture   = finishing && !isWrite;
        fifoPop         = finishing && isWrite;
        xferDone        = (count == '0) && fifoStatus.empty;
    end

endmodule

`default_nettype wire

/* hw/cpuBusPort.sv */
// Module cpuBusPort: address counter, data lane steering, read capture and termination decode
`timescale 1ns/10ps
`default_nettype none
`include "dmac_config.svh"

module cpuBusPort (
    input  wire                        CLK,
    input  wire                        nRESET,
    input  wire                        start,
    input  wire [`DMAC_ADDR_W-1:0]     startAddr,
    input  wire dmacPkg::busCycleT     cycle,
    input  wire [31:0]                 fifoRdData,
    output logic [31:0]                captureData,
    output logic                       capturePush,
    input  wire [1:0]                  nDsack,
    input  wire                        nSterm,
    output dmacPkg::termKindT          term,
    output logic [`DMAC_ADDR_W-1:0]    addr,
    output logic [31:0]                dataOut,
    output logic                       dataOe,
    input  wire [31:0]                 dataIn,
    output logic                       nAs,
    output logic                       nDs,
    output logic                       rw,
    output logic                       siz16
);

    dmacPkg::termKindT        termNext;
    logic [`DMAC_ADDR_W-1:0]  addrInc;
    logic [31:0]              rdLatch;     // Sampled with the termination
    logic [15:0]              upperHold;   // Upper word of a split read

    always_comb begin
        if (!nSterm || (nDsack == 2'b00)) begin
            termNext = dmacPkg::term32;
        end else if (nDsack == 2'b01) begin
            termNext = dmacPkg::term16;
        end else begin
            termNext = dmacPkg::termNone;
        end
        addrInc = (cycle.upperHalf && (term == dmacPkg::term32)) ?
                  `DMAC_ADDR_W'(4) : `DMAC_ADDR_W'(2);
    end

    always_ff @(posedge CLK or negedge nRESET) begin
        if (!nRESET) begin
            term <= dmacPkg::termNone;
            addr <= '0;
        end else begin
            term <= cycle.strobe ? termNext : dmacPkg::termNone;
            if (start) begin
                addr <= startAddr;
            end else if (cycle.addrStep) begin
                addr <= addr + addrInc;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (cycle.strobe) begin
            rdLatch <= dataIn;
        end
        if (cycle.addrStep && cycle.upperHalf) begin
            upperHold <= rdLatch[31:16];           // 16-bit port answers on D31:16
        end
    end

    always_comb begin
        captureData = cycle.upperHalf ? rdLatch : {upperHold, rdLatch[31:16]};
        capturePush = cycle.capture;
        // Lower word is duplicated so a 16-bit port sees it on D31:16
        dataOut     = cycle.upperHalf ? fifoRdData : {fifoRdData[15:0], fifoRdData[15:0]};
        dataOe      = cycle.master && !cycle.rw;
        nAs         = !cycle.strobe;
        nDs         = !cycle.strobe;
        rw          = cycle.rw;
        siz16       = cycle.master && !cycle.upperHalf;
    end

endmodule

`default_nettype wire

/* hw/dmacCore.sv */
// Module dmacCore: DMA controller top with peripheral port, FIFO, bus FSM and bus pins
`timescale 1ns/10ps
`default_nettype none
`include "dmac_config.svh"

module dmacCore (
    input  wire                        CLK,
    input  wire                        nRESET,
    input  wire                        periphWrStb,
    input  wire [15:0]                 periphWrData,
    input  wire                        periphRdStb,
    output logic [15:0]                periphRdData,
    output logic                       periphFull,
    output logic                       periphEmpty,
    input  wire                        start,
    input  wire                        dmaEna,
    input  wire dmacPkg::xferDirT      dmaDir,
    input  wire [`DMAC_ADDR_W-1:0]     startAddr,
    input  wire [`DMAC_COUNT_W-1:0]    longCount,
    output logic                       xferDone,
    output logic [`DMAC_ADDR_W-1:0]    addr,
    output logic [31:0]                dataOut,
    output logic                       dataOe,
    input  wire [31:0]                 dataIn,
    output logic                       nAs,
    output logic                       nDs,
    output logic                       rw,
    output logic                       siz16,
    output logic                       nBr,
    input  wire                        nBg,
    output logic                       nBgack,
    input  wire [1:0]                  nDsack,
    input  wire                        nSterm
);

    dmacPkg::fifoStatusT fifoStatus;
    dmacPkg::busCycleT   cycle;
    dmacPkg::termKindT   term;
    logic [31:0]         fifoRdData;
    logic [31:0]         fifoWrData;
    logic                fifoPush;
    logic                fifoPop;
    logic [31:0]         periphLong;
    logic                periphPush;
    logic                periphPop;
    logic [31:0]         captureData;
    logic                capturePush;
    logic                busPop;
    logic                isWrite;

    // FIFO writer and reader swap with the transfer direction
    always_comb begin
        isWrite    = (dmaDir == dmacPkg::memWrite);
        fifoWrData = isWrite ? periphLong : captureData;
        fifoPush   = isWrite ? periphPush : capturePush;
        fifoPop    = isWrite ? busPop : periphPop;
    end

    peripheralPort peripheralPort_inst (
        .CLK(CLK), .nRESET(nRESET),
        .periphWrStb(periphWrStb), .periphWrData(periphWrData),
        .periphRdStb(periphRdStb), .periphRdData(periphRdData),
        .periphFull(periphFull), .periphEmpty(periphEmpty),
        .fifoWrData(periphLong), .fifoPush(periphPush),
        .fifoRdData(fifoRdData), .fifoPop(periphPop), .fifoStatus(fifoStatus)
    );

    dmaFifo dmaFifo_inst (
        .CLK(CLK), .nRESET(nRESET), .start(start),
        .wrData(fifoWrData), .push(fifoPush),
        .rdData(fifoRdData), .pop(fifoPop), .status(fifoStatus)
    );

    cpuBusSm cpuBusSm_inst (
        .CLK(CLK), .nRESET(nRESET), .start(start), .dmaEna(dmaEna), .dmaDir(dmaDir),
        .longCount(longCount), .fifoStatus(fifoStatus), .term(term), .nBg(nBg),
        .nBr(nBr), .nBgack(nBgack), .cycle(cycle), .fifoPop(busPop), .xferDone(xferDone)
    );

    cpuBusPort cpuBusPort_inst (
        .CLK(CLK), .nRESET(nRESET), .start(start), .startAddr(startAddr),
        .cycle(cycle), .fifoRdData(fifoRdData),
        .captureData(captureData), .capturePush(capturePush),
        .nDsack(nDsack), .nSterm(nSterm), .term(term),
        .addr(addr), .dataOut(dataOut), .dataOe(dataOe), .dataIn(dataIn),
        .nAs(nAs), .nDs(nDs), .rw(rw), .siz16(siz16)
    );

endmodule

`default_nettype wire

/* verification/tbClockGen.sv */
// Module tbClockGen: testbench clock and active-low reset generator
`timescale 1ns/10ps
`default_nettype none

module tbClockGen #(
    parameter real periodNs    = 8.0,
    parameter int  resetCycles = 2
) (
    output logic CLK,
    output logic nRESET
);

    initial begin
        CLK = 1'b0;
        forever #(periodNs / 2.0) CLK = ~CLK;
    end

    initial begin
        nRESET = 1'b0;
        repeat (resetCycles) @(posedge CLK);
        @(negedge CLK);
        nRESET = 1'b1;                 // Released away from the active edge
    end

endmodule

`default_nettype wire

/* verification/tbBusMemory.sv */
// Module tbBusMemory: bus arbiter, longword memory with fill pattern, termination and cycle log
`timescale 1ns/10ps
`default_nettype none

module tbBusMemory #(
    parameter logic [31:0] memBase = 32'h0000_1000
) (
    input  wire         CLK,
    input  wire         nRESET,
    input  wire         port16,        // Answers on D31:16 with nDsack[1] only
    input  wire         useSterm,
    input  wire  [3:0]  maxWait,
    input  wire  [3:0]  maxGrantDelay,
    input  wire         nBr,
    input  wire         nBgack,
    output logic        nBg,
    input  wire  [31:0] addr,
    input  wire  [31:0] dataOut,
    output logic [31:0] dataIn,
    input  wire         nAs,
    input  wire         rw,
    input  wire         siz16,
    output logic [1:0]  nDsack,
    output logic        nSterm
);

    logic [31:0] mem [64];
    logic [31:0] cycleAddr [256];      // Address of every bus cycle in order
    logic        cycleSiz16 [256];
    int          cycleCount;
    int          waitLeft;
    int          grantLeft;
    logic        acked;
    logic        inCycle;
    logic [5:0]  wordIdx;

    assign wordIdx = addr[7:2];

    function automatic logic [31:0] fillWord(input logic [31:0] a);
        return (a * 32'h9E37_79B1) ^ 32'hC3A5_5A3C;
    endfunction

    initial begin
        nBg        <= 1'b1;
        nDsack     <= 2'b11;
        nSterm     <= 1'b1;
        dataIn     <= '0;
        cycleCount <= 0;
        waitLeft   <= 0;
        grantLeft  <= 0;
        acked      <= 1'b0;
        inCycle    <= 1'b0;
        for (int i = 0; i < 64; i++) begin
            mem[i] <= fillWord(memBase + 32'(4 * i));
        end
    end

    always @(negedge CLK) begin
        if (!nRESET) begin
            nBg     <= 1'b1;
            nDsack  <= 2'b11;
            nSterm  <= 1'b1;
            acked   <= 1'b0;
            inCycle <= 1'b0;
        end else begin
            // Grant after a random delay, withdrawn once nBgack is taken
            if (!nBgack || nBr) begin
                nBg       <= 1'b1;
                grantLeft <= $urandom % (maxGrantDelay + 1);
            end else if (grantLeft == 0) begin
                nBg <= 1'b0;
            end else begin
                grantLeft <= grantLeft - 1;
            end
            if (nAs) begin
                nDsack   <= 2'b11;
                nSterm   <= 1'b1;
                acked    <= 1'b0;
                inCycle  <= 1'b0;
                waitLeft <= $urandom % (maxWait + 1);
            end else begin
                if (!inCycle) begin
                    cycleAddr[cycleCount[7:0]]  <= addr;
                    cycleSiz16[cycleCount[7:0]] <= siz16;
                    cycleCount                  <= cycleCount + 1;
                    inCycle                     <= 1'b1;
                end
                if (!acked && waitLeft != 0) begin
                    waitLeft <= waitLeft - 1;
                end else if (!acked) begin
                    acked  <= 1'b1;
                    nSterm <= !useSterm;
                    nDsack <= useSterm ? 2'b11 : (port16 ? 2'b01 : 2'b00);
                    if (rw && port16) begin
                        dataIn <= {(addr[1] ? mem[wordIdx][15:0] : mem[wordIdx][31:16]), 16'h0};
                    end else if (rw) begin
                        dataIn <= mem[wordIdx];
                    end else if (!port16) begin
                        mem[wordIdx] <= dataOut;
                    end else if (addr[1]) begin
                        mem[wordIdx][15:0] <= dataOut[31:16];
                    end else begin
                        mem[wordIdx][31:16] <= dataOut[31:16];
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

/* verification/tbDmac.sv */
// Testbench top tbDmac: DUT, bus model, bus protocol monitor, directed DMA tests and summary
`timescale 1ns/10ps
`default_nettype none
`include "dmac_config.svh"

module tbDmac;

    localparam int timeoutCycles = 3000;
    localparam int condRoom      = 0;
    localparam int condData      = 1;
    localparam int condDone      = 2;
    localparam int condReset     = 3;

    logic                     CLK;
    logic                     nRESET;
    logic                     periphWrStb;
    logic [15:0]              periphWrData;
    logic                     periphRdStb;
    logic [15:0]              periphRdData;
    logic                     periphFull;
    logic                     periphEmpty;
    logic                     start;
    logic                     dmaEna;
    dmacPkg::xferDirT         dmaDir;
    logic [`DMAC_ADDR_W-1:0]  startAddr;
    logic [`DMAC_COUNT_W-1:0] longCount;
    logic                     xferDone;
    logic [`DMAC_ADDR_W-1:0]  addr;
    logic [31:0]              dataOut;
    logic                     dataOe;
    logic [31:0]              dataIn;
    logic                     nAs;
    logic                     nDs;
    logic                     rw;
    logic                     siz16;
    logic                     nBr;
    logic                     nBg;
    logic                     nBgack;
    logic [1:0]               nDsack;
    logic                     nSterm;
    logic                     port16;
    logic                     useSterm;
    logic [3:0]               maxWait;
    logic [3:0]               maxGrantDelay;
    logic [15:0]              halfwords [64];
    int                       checkErrors;
    int                       timeouts;
    int                       seedInit;
    int                       protocolErrors = 0;
    int                       tenureCount = 0;
    int                       asFalls = 0;
    logic                     prevBgack = 1'b1;
    logic                     prevAs = 1'b1;
    logic                     grantSeen = 1'b0;

    tbClockGen clockGen_inst (.CLK(CLK), .nRESET(nRESET));
    tbBusMemory busMem_inst (.*);
    dmacCore dmacCore_inst (.*);

    // Bus protocol monitor
    always @(negedge CLK) begin
        if (nRESET) begin
            prevBgack <= nBgack;
            prevAs    <= nAs;
            if (!nAs && nBgack) begin
                protocolErrors <= protocolErrors + 1;
                $display("ERROR: nAs asserted while nBgack is high at %0t", $time);
            end
            if (!nAs && (dataOe !== !rw)) begin
                protocolErrors <= protocolErrors + 1;
                $display("ERROR: data bus drive does not match rw in a bus cycle at %0t", $time);
            end
            if (nDs !== nAs) begin
                protocolErrors <= protocolErrors + 1;
                $display("ERROR: nDs does not follow nAs at %0t", $time);
            end
            if (prevBgack && !nBgack && !grantSeen && nBg) begin
                protocolErrors <= protocolErrors + 1;
                $display("ERROR: nBgack asserted without a prior bus grant at %0t", $time);
            end
            if (!prevBgack && nBgack) begin    // End of a tenure
                tenureCount <= tenureCount + 1;
                grantSeen   <= 1'b0;
                asFalls     <= 0;
                if (!port16 && asFalls > `DMAC_BURST_MAX) begin
                    protocolErrors <= protocolErrors + 1;
                    $display("ERROR: %0d bus cycles in one tenure at %0t", asFalls, $time);
                end
            end else begin
                grantSeen <= grantSeen || !nBg;
                if (prevAs && !nAs) begin
                    asFalls <= asFalls + 1;
                end
            end
        end
    end

    function automatic logic [31:0] expectedFill(input logic [31:0] a);
        return (a * 32'h9E37_79B1) ^ 32'hC3A5_5A3C;
    endfunction

    function automatic bit isReady(input int which);
        case (which)
            condRoom: return !periphFull;
            condData: return !periphEmpty;
            condDone: return xferDone;
            default:  return nRESET;
        endcase
    endfunction

    task automatic compareValue(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        if (actual !== expected) begin
            checkErrors++;
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic awaitReady(input int which, input string what, output bit ok);
        int waited;
        waited = 0;
        while (!isReady(which) && waited < timeoutCycles) begin
            @(negedge CLK);
            waited++;
        end
        ok = isReady(which);
        if (!ok) begin
            timeouts++;
            $display("ERROR: timed out waiting for %s", what);
        end
    endtask

    task automatic startTransfer(input dmacPkg::xferDirT dir, input logic [31:0] base,
                                 input int n);
        @(negedge CLK);
        dmaDir    = dir;
        startAddr = base;
        longCount = `DMAC_COUNT_W'(n);
        start     = 1'b1;
        @(negedge CLK);
        start  = 1'b0;
        dmaEna = 1'b1;
    endtask

    task automatic checkResetState();
        bit ok;
        awaitReady(condReset, "reset release", ok);
        @(negedge CLK);
        compareValue("reset nBr", 32'(1), 32'(nBr));
        compareValue("reset nBgack", 32'(1), 32'(nBgack));
        compareValue("reset nAs", 32'(1), 32'(nAs));
        compareValue("reset nDs", 32'(1), 32'(nDs));
        compareValue("reset rw", 32'(1), 32'(rw));
        compareValue("reset dataOe", 32'(0), 32'(dataOe));
        compareValue("reset xferDone", 32'(1), 32'(xferDone));
    endtask

    task automatic memWriteTest(input string name, input logic [31:0] base, input int n,
                                input bit p16, input bit sterm, input logic [3:0] waits,
                                input logic [3:0] grantDelay);
        bit ok;
        int logBase;
        port16        = p16;
        useSterm      = sterm;
        maxWait       = waits;
        maxGrantDelay = grantDelay;
        logBase       = busMem_inst.cycleCount;
        startTransfer(dmacPkg::memWrite, base, n);
        for (int i = 0; i < 2 * n; i++) begin
            halfwords[i] = 16'($urandom);
            periphWrStb  = 1'b0;
            awaitReady(condRoom, {name, " FIFO room"}, ok);
            if (!ok) return;
            periphWrStb  = 1'b1;
            periphWrData = halfwords[i];
            @(negedge CLK);
        end
        periphWrStb = 1'b0;
        awaitReady(condDone, {name, " xferDone"}, ok);
        dmaEna = 1'b0;
        if (!ok) return;
        for (int i = 0; i < n; i++) begin          // Big-endian pairs at consecutive longwords
            compareValue($sformatf("%s long %0d", name, i), {halfwords[2 * i],
                         halfwords[2 * i + 1]}, busMem_inst.mem[base[7:2] + i]);
        end
        if (p16) begin
            compareValue({name, " cycle count"}, 32'(2 * n),
                         32'(busMem_inst.cycleCount - logBase));
            for (int i = 0; i < n; i++) begin
                compareValue($sformatf("%s upper addr %0d", name, i), base + 32'(4 * i),
                             busMem_inst.cycleAddr[(logBase + 2 * i) % 256]);
                compareValue($sformatf("%s lower addr %0d", name, i), base + 32'(4 * i + 2),
                             busMem_inst.cycleAddr[(logBase + 2 * i + 1) % 256]);
                compareValue($sformatf("%s lower siz16 %0d", name, i), 32'(1),
                             32'(busMem_inst.cycleSiz16[(logBase + 2 * i + 1) % 256]));
            end
        end
    endtask

    task automatic memReadTest(input logic [31:0] base, input int n);
        bit          ok;
        logic [31:0] expected;
        port16        = 1'b0;
        useSterm      = 1'b0;
        maxWait       = 4'd2;
        maxGrantDelay = 4'd3;
        startTransfer(dmacPkg::memRead, base, n);
        for (int i = 0; i < 2 * n; i++) begin
            expected = expectedFill(base + 32'(4 * (i / 2)));
            awaitReady(condData, "peripheral read data", ok);
            if (!ok) return;
            compareValue($sformatf("read half %0d", i),
                         (i % 2 == 0) ? {16'h0, expected[31:16]} : {16'h0, expected[15:0]},
                         {16'h0, periphRdData});
            periphRdStb = 1'b1;
            @(negedge CLK);
            periphRdStb = 1'b0;
        end
        compareValue("read periphEmpty at end", 32'(1), 32'(periphEmpty));
        awaitReady(condDone, "read xferDone", ok);
        dmaEna = 1'b0;
    endtask

    task automatic arbitrationTest();
        int errorsBefore;
        int tenuresBefore;
        errorsBefore  = protocolErrors;
        tenuresBefore = tenureCount;
        memWriteTest("arbitration", 32'h0000_1060, 12, 1'b0, 1'b0, 4'd1, 4'd7);
        @(negedge CLK);                            // Last tenure end settles in the monitor
        compareValue("arbitration protocol errors", 32'(errorsBefore), 32'(protocolErrors));
        compareValue("arbitration at least 3 tenures", 32'(1),
                     32'((tenureCount - tenuresBefore) >= 3 ? 1 : 0));
    endtask

    initial begin
        seedInit      = $urandom(16);              // Fixed seed for the run
        checkErrors   = 0;
        timeouts      = 0;
        periphWrStb   = 1'b0;
        periphWrData  = '0;
        periphRdStb   = 1'b0;
        start         = 1'b0;
        dmaEna        = 1'b0;
        dmaDir        = dmacPkg::memWrite;
        startAddr     = '0;
        longCount     = '0;
        port16        = 1'b0;
        useSterm      = 1'b0;
        maxWait       = 4'd0;
        maxGrantDelay = 4'd3;
        checkResetState();
        if (timeouts == 0) memWriteTest("write32", 32'h0000_1000, 8, 1'b0, 1'b0, 4'd0, 4'd3);
        if (timeouts == 0) memWriteTest("writeSterm", 32'h0000_1020, 8, 1'b0, 1'b1, 4'd3, 4'd3);
        if (timeouts == 0) memWriteTest("write16", 32'h0000_1040, 6, 1'b1, 1'b0, 4'd2, 4'd3);
        if (timeouts == 0) memReadTest(32'h0000_10C0, 10);
        if (timeouts == 0) arbitrationTest();
        repeat (4) @(negedge CLK);
        $display("Summary: %0d check errors, %0d protocol errors, %0d timeouts",
                 checkErrors, protocolErrors, timeouts);
        if (checkErrors + protocolErrors + timeouts == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
+incdir+hw
hw/dmacPkg.sv
hw/peripheralPort.sv
hw/dmaFifo.sv
hw/cpuBusSm.sv
hw/cpuBusPort.sv
hw/dmacCore.sv
verification/tbClockGen.sv
verification/tbBusMemory.sv
verification/tbDmac.sv
